/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // Width of every fetch address and branch target
    localparam int addr_w = 32;

    // First fetch address out of reset
    localparam logic [addr_w-1:0] reset_pc = 32'h0000_1000;

    // Two-bit saturating counter
    typedef logic [1:0] ctr_t;

    // Counter encoding, taken once at or above weakly taken
    localparam ctr_t ctr_strong_not_taken = 2'b00;
    localparam ctr_t ctr_weak_not_taken = 2'b01;
    localparam ctr_t ctr_weak_taken = 2'b10;
    localparam ctr_t ctr_strong_taken = 2'b11;

    // Default sizes, overridden from the top level
    localparam int default_hist_bits = 4;
    localparam int default_btb_entries = 16;
    localparam int default_corr_depth = 4;

endpackage

`default_nettype wire

/* global_history_register.sv */
`timescale 1ns/100ps
`default_nettype none

module global_history_register #(
    parameter int hist_bits = bp_pkg::default_hist_bits
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 id_ex_branch,
    input  wire                 pcsrc,
    output logic [hist_bits-1:0] branch_history
);

    // Newest outcome enters at bit 0
    // Oldest outcome falls off the top
    logic [hist_bits-1:0] history_shifted;

    assign history_shifted = {branch_history[hist_bits-2:0], pcsrc};

    // Only resolved branches move the history
    // Jumps and plain fetches leave it alone
    always_ff @(posedge clk) begin
        if (reset) begin
            // All not taken out of reset
            branch_history <= '0;
        end else if (id_ex_branch) begin
            branch_history <= history_shifted;
        end
    end

endmodule

`default_nettype wire

/* pattern_history_table.sv */
`timescale 1ns/100ps
`default_nettype none

module pattern_history_table #(
    parameter int hist_bits = bp_pkg::default_hist_bits
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 id_ex_branch,
    input  wire                 pcsrc,
    input  wire [hist_bits-1:0] branch_history,
    output logic                taken
);

    import bp_pkg::*;

    // One counter per history pattern
    localparam int entries = 2 ** hist_bits;

    ctr_t counters [entries];

    // Counter currently selected by the history
    ctr_t cur_ctr;
    // Value it moves to on a resolution
    ctr_t next_ctr;

    assign cur_ctr = counters[branch_history];

    // Same as the counter's upper bit
    assign taken = (cur_ctr >= ctr_weak_taken);

    // Saturating step in the resolved direction
    always_comb begin
        next_ctr = cur_ctr;
        if (pcsrc) begin
            if (cur_ctr != ctr_strong_taken) begin
                next_ctr = cur_ctr + 2'd1;
            end
        end else begin
            if (cur_ctr != ctr_strong_not_taken) begin
                next_ctr = cur_ctr - 2'd1;
            end
        end
    end

    // Training uses the history before this edge's shift,
    // i.e. the pattern the branch was predicted with
    always_ff @(posedge clk) begin
        if (reset) begin
            // Every entry starts weakly not taken
            for (int i = 0; i < entries; i++) begin
                counters[i] <= ctr_weak_not_taken;
            end
        end else if (id_ex_branch) begin
            counters[branch_history] <= next_ctr;
        end
    end

endmodule

`default_nettype wire

/* branch_target_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer #(
    parameter int btb_entries = bp_pkg::default_btb_entries
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       id_ex_branch,
    input  wire                       pcsrc,
    input  wire [bp_pkg::addr_w-1:0]  id_ex_pc,
    input  wire [bp_pkg::addr_w-1:0]  pc_branch,
    input  wire [bp_pkg::addr_w-1:0]  pc,
    output logic [bp_pkg::addr_w-1:0] pc_target,
    output logic                      hit
);

    import bp_pkg::*;

    // Index sits just above the two word-offset bits
    localparam int idx_w = $clog2(btb_entries);
    // Tag is everything above the index
    localparam int tag_w = addr_w - idx_w - 2;

    // Entry storage
    logic              entry_valid [btb_entries];
    logic [tag_w-1:0]  entry_tag [btb_entries];
    logic [addr_w-1:0] entry_target [btb_entries];

    // Lookup side, from the fetch PC
    logic [idx_w-1:0] lookup_idx;
    logic [tag_w-1:0] lookup_tag;

    // Update side, from the resolving branch
    logic [idx_w-1:0] write_idx;
    logic [tag_w-1:0] write_tag;
    logic             write_en;

    assign lookup_idx = pc[idx_w+1:2];
    assign lookup_tag = pc[addr_w-1:idx_w+2];

    assign write_idx = id_ex_pc[idx_w+1:2];
    assign write_tag = id_ex_pc[addr_w-1:idx_w+2];

    // Only taken branches install a target
    assign write_en = id_ex_branch && pcsrc;

    // Combinational lookup
    // Target is meaningless without hit
    assign hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    assign pc_target = entry_target[lookup_idx];

    // Valid bits cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < btb_entries; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (write_en) begin
            entry_valid[write_idx] <= 1'b1;
        end
    end

    // Tag and target follow the valid bit
    // Aliasing branch simply replaces the old one
    always_ff @(posedge clk) begin
        if (write_en) begin
            entry_tag[write_idx] <= write_tag;
            entry_target[write_idx] <= pc_branch;
        end
    end

endmodule

`default_nettype wire

/* branch_correction_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_correction_buffer #(
    parameter int corr_depth = bp_pkg::default_corr_depth
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [bp_pkg::addr_w-1:0]  pc,
    input  wire                       hit,
    input  wire                       taken,
    input  wire [bp_pkg::addr_w-1:0]  pc_target,
    input  wire                       id_ex_branch,
    input  wire                       id_ex_hit,
    input  wire                       pcsrc,
    output logic [bp_pkg::addr_w-1:0] pc_reverse,
    output logic                      wrong
);

    import bp_pkg::*;

    localparam int ptr_w = $clog2(corr_depth);
    localparam int cnt_w = $clog2(corr_depth + 1);

    // Queue payload, no reset needed
    logic              dir_mem [corr_depth];
    logic [addr_w-1:0] alt_mem [corr_depth];

    // Queue control
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    logic             empty;
    logic             full;
    logic             push;
    logic             pop;
    logic [addr_w-1:0] alt_pc;

    // Circular pointer step, depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(corr_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == cnt_w'(corr_depth));

    // Every predicted fetch is recorded
    // Record dropped when full
    assign push = hit && !full;
    // Branches that hit at fetch retire their record in order
    assign pop = id_ex_branch && id_ex_hit && !empty;

    // Path the fetch did not follow
    assign alt_pc = taken ? (pc + addr_w'(4)) : pc_target;

    // Oldest record against the real outcome
    assign wrong = pop && (dir_mem[rd_ptr] != pcsrc);
    assign pc_reverse = alt_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (wrong) begin
            // Everything younger was fetched down the bad path
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Fetch in a flush cycle is on the bad path too
    always_ff @(posedge clk) begin
        if (push && !wrong) begin
            dir_mem[wr_ptr] <= taken;
            alt_mem[wr_ptr] <= alt_pc;
        end
    end

endmodule

`default_nettype wire

/* fetch_pc_select.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_select (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       taken,
    input  wire                       hit,
    input  wire [bp_pkg::addr_w-1:0]  pc_target,
    input  wire                       wrong,
    input  wire [bp_pkg::addr_w-1:0]  pc_reverse,
    input  wire                       id_ex_jump,
    input  wire                       id_ex_hit,
    input  wire                       pcsrc,
    input  wire [bp_pkg::addr_w-1:0]  pc_branch,
    output logic [bp_pkg::addr_w-1:0] pc,
    output logic                      pc_taken,
    output logic                      miss_redirect
);

    import bp_pkg::*;

    logic [addr_w-1:0] pc_plus4;
    logic [addr_w-1:0] pc_next;

    assign pc_plus4 = pc + addr_w'(4);

    // Predicted taken only with a known target
    assign pc_taken = taken && hit;

    // Taken branch the buffer never saw at fetch
    assign miss_redirect = pcsrc && !id_ex_hit;

    // Next fetch address, EX redirect wins over everything
    always_comb begin
        if (id_ex_jump || miss_redirect) begin
            pc_next = pc_branch;
        end else if (wrong) begin
            // Back onto the path recorded at fetch
            pc_next = pc_reverse;
        end else if (pc_taken) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // No stall, a new address every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* global_prediction_top.sv */
`timescale 1ns/100ps
`default_nettype none

module global_prediction_top #(
    parameter int hist_bits = bp_pkg::default_hist_bits,
    parameter int btb_entries = bp_pkg::default_btb_entries,
    parameter int corr_depth = bp_pkg::default_corr_depth
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       id_ex_branch,
    input  wire                       pcsrc,
    input  wire [bp_pkg::addr_w-1:0]  id_ex_pc,
    input  wire [bp_pkg::addr_w-1:0]  pc_branch,
    input  wire                       id_ex_jump,
    input  wire                       id_ex_hit,
    output logic [bp_pkg::addr_w-1:0] pc,
    output logic                      wrong,
    output logic                      miss_redirect,
    output logic                      hit,
    output logic                      pc_taken
);

    import bp_pkg::*;

    // Between predictor blocks
    logic [hist_bits-1:0] branch_history;
    logic                 taken;
    logic [addr_w-1:0]    pc_target;
    logic [addr_w-1:0]    pc_reverse;

    // Outcome history from EX
    global_history_register #(
        .hist_bits(hist_bits)
    ) ghr_i (
        .clk(clk),
        .reset(reset),
        .id_ex_branch(id_ex_branch),
        .pcsrc(pcsrc),
        .branch_history(branch_history)
    );

    // Direction from the history pattern
    pattern_history_table #(
        .hist_bits(hist_bits)
    ) pht_i (
        .clk(clk),
        .reset(reset),
        .id_ex_branch(id_ex_branch),
        .pcsrc(pcsrc),
        .branch_history(branch_history),
        .taken(taken)
    );

    // Target for the current fetch PC
    branch_target_buffer #(
        .btb_entries(btb_entries)
    ) btb_i (
        .clk(clk),
        .reset(reset),
        .id_ex_branch(id_ex_branch),
        .pcsrc(pcsrc),
        .id_ex_pc(id_ex_pc),
        .pc_branch(pc_branch),
        .pc(pc),
        .pc_target(pc_target),
        .hit(hit)
    );

    // Recovery addresses for predicted branches
    branch_correction_buffer #(
        .corr_depth(corr_depth)
    ) bcb_i (
        .clk(clk),
        .reset(reset),
        .pc(pc),
        .hit(hit),
        .taken(taken),
        .pc_target(pc_target),
        .id_ex_branch(id_ex_branch),
        .id_ex_hit(id_ex_hit),
        .pcsrc(pcsrc),
        .pc_reverse(pc_reverse),
        .wrong(wrong)
    );

    // PC register and next-address priority
    fetch_pc_select pc_sel_i (
        .clk(clk),
        .reset(reset),
        .taken(taken),
        .hit(hit),
        .pc_target(pc_target),
        .wrong(wrong),
        .pc_reverse(pc_reverse),
        .id_ex_jump(id_ex_jump),
        .id_ex_hit(id_ex_hit),
        .pcsrc(pcsrc),
        .pc_branch(pc_branch),
        .pc(pc),
        .pc_taken(pc_taken),
        .miss_redirect(miss_redirect)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    // Low for the first half period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(period_ns / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* global_prediction_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module global_prediction_properties (
    input wire                      clk,
    input wire                      reset,
    input wire                      id_ex_branch,
    input wire [bp_pkg::addr_w-1:0] pc_branch,
    input wire [bp_pkg::addr_w-1:0] pc,
    input wire                      wrong,
    input wire                      miss_redirect
);

    import bp_pkg::*;

    // Number of failed properties so far
    int fail_count = 0;

    // Fetch addresses stay on word boundaries
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc 0x%h is not word aligned", pc);
            fail_count++;
        end

    // Misprediction only comes out of a resolving branch
    wrong_needs_branch: assert property (@(posedge clk) disable iff (reset)
        wrong |-> id_ex_branch)
        else begin
            $error("wrong raised without id_ex_branch");
            fail_count++;
        end

    // Reset vector loaded by the reset edge
    pc_after_reset: assert property (@(posedge clk) reset |=> pc == reset_pc)
        else begin
            $error("pc 0x%h is not the reset vector after reset", pc);
            fail_count++;
        end

    // Unpredicted taken branch goes straight to its target
    miss_goes_to_target: assert property (@(posedge clk) disable iff (reset)
        miss_redirect |=> pc == $past(pc_branch))
        else begin
            $error("pc 0x%h did not follow the missed branch target", pc);
            fail_count++;
        end

endmodule

bind global_prediction_top global_prediction_properties props_i (
    .clk(clk),
    .reset(reset),
    .id_ex_branch(id_ex_branch),
    .pc_branch(pc_branch),
    .pc(pc),
    .wrong(wrong),
    .miss_redirect(miss_redirect)
);

`default_nettype wire

/* global_prediction_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module global_prediction_tb;

    import bp_pkg::*;

    localparam int period_ns = 40;
    localparam int reset_cycles = 8;

    // EX inputs of one cycle and the outputs expected in that cycle
    typedef struct packed {
        logic              branch;
        logic              src;
        logic [addr_w-1:0] ex_pc;
        logic [addr_w-1:0] target;
        logic              jump;
        logic              ex_hit;
        logic [addr_w-1:0] exp_pc;
        logic              exp_hit;
        logic              exp_pc_taken;
        logic              exp_miss;
        logic              exp_wrong;
    } row_t;

    logic              clk;
    logic              reset;
    logic              id_ex_branch;
    logic              pcsrc;
    logic [addr_w-1:0] id_ex_pc;
    logic [addr_w-1:0] pc_branch;
    logic              id_ex_jump;
    logic              id_ex_hit;
    logic [addr_w-1:0] pc;
    logic              wrong;
    logic              miss_redirect;
    logic              hit;
    logic              pc_taken;

    row_t  rows [$];
    string names [$];
    bit    rows_loaded = 1'b0;
    int    row_errors;
    int    total_errors;
    int    failed_tests;
    int    prop_failures;

    tb_clock_gen #(
        .period_ns(period_ns)
    ) clk_gen_i (
        .clk(clk)
    );

    global_prediction_top #(
        .hist_bits(default_hist_bits),
        .btb_entries(default_btb_entries),
        .corr_depth(default_corr_depth)
    ) global_prediction_top_i (
        .clk(clk),
        .reset(reset),
        .id_ex_branch(id_ex_branch),
        .pcsrc(pcsrc),
        .id_ex_pc(id_ex_pc),
        .pc_branch(pc_branch),
        .id_ex_jump(id_ex_jump),
        .id_ex_hit(id_ex_hit),
        .pc(pc),
        .wrong(wrong),
        .miss_redirect(miss_redirect),
        .hit(hit),
        .pc_taken(pc_taken)
    );

    task automatic add_row(input string name, input logic br, input logic src,
                           input logic [addr_w-1:0] ex_pc, input logic [addr_w-1:0] target,
                           input logic jump, input logic ex_hit,
                           input logic [addr_w-1:0] exp_pc, input logic exp_hit,
                           input logic exp_pt, input logic exp_miss, input logic exp_wrong);
        rows.push_back({br, src, ex_pc, target, jump, ex_hit,
                        exp_pc, exp_hit, exp_pt, exp_miss, exp_wrong});
        names.push_back(name);
    endtask

    // Branch B at 0x3000 with target 0x4000, BTB index 0
    // History and counters traced by hand, counters start at 01
    task automatic load_table();
        add_row("idle after reset", 0, 0, 0, 0, 0, 0, 32'h1000, 0, 0, 0, 0);
        add_row("idle +4", 0, 0, 0, 0, 0, 0, 32'h1004, 0, 0, 0, 0);
        add_row("idle +4", 0, 0, 0, 0, 0, 0, 32'h1008, 0, 0, 0, 0);
        // id_ex_hit set as well, a jump still wins
        add_row("jump to 0x2000", 0, 0, 0, 32'h2000, 1, 1, 32'h100c, 0, 0, 0, 0);
        add_row("after jump", 0, 0, 0, 0, 0, 0, 32'h2000, 0, 0, 0, 0);
        // Hist 0000, C[0] to 10, BTB learns B
        add_row("taken, buffer miss", 1, 1, 32'h3000, 32'h4000, 0, 0, 32'h2004, 0, 0, 1, 0);
        add_row("jump back to B", 0, 0, 0, 32'h3000, 1, 0, 32'h4000, 0, 0, 0, 0);
        // Hist 0001, C[1] weakly not taken, records alternate 0x4000
        add_row("hit, weak counter", 0, 0, 0, 0, 0, 0, 32'h3000, 1, 0, 0, 0);
        // Predicted not taken, resolved taken, back to 0x4000
        add_row("not-taken mispredict", 1, 1, 32'h3000, 32'h4000, 0, 1, 32'h3004, 0, 0, 0, 1);
        // Three more taken, history ends at 1111 with C[15] at 10
        add_row("train taken", 1, 1, 32'h3000, 32'h4000, 0, 0, 32'h4000, 0, 0, 1, 0);
        add_row("train taken", 1, 1, 32'h3000, 32'h4000, 0, 0, 32'h4000, 0, 0, 1, 0);
        add_row("train taken", 1, 1, 32'h3000, 32'h4000, 0, 0, 32'h4000, 0, 0, 1, 0);
        add_row("jump back to B", 0, 0, 0, 32'h3000, 1, 0, 32'h4000, 0, 0, 0, 0);
        add_row("predicted taken", 0, 0, 0, 0, 0, 0, 32'h3000, 1, 1, 0, 0);
        // Recorded alternate is B + 4
        add_row("taken mispredict", 1, 0, 32'h3000, 32'h4000, 0, 1, 32'h4000, 0, 0, 0, 1);
        add_row("recovered path", 0, 0, 0, 0, 0, 0, 32'h3004, 0, 0, 0, 0);
        add_row("jump back to B", 0, 0, 0, 32'h3000, 1, 0, 32'h3008, 0, 0, 0, 0);
        // Hist 1110, C[14] never trained
        add_row("hit, untrained pattern", 0, 0, 0, 0, 0, 0, 32'h3000, 1, 0, 0, 0);
        add_row("fall through", 0, 0, 0, 0, 0, 0, 32'h3004, 0, 0, 0, 0);
    endtask

    task automatic idle_inputs();
        id_ex_branch = 1'b0;
        pcsrc = 1'b0;
        id_ex_pc = '0;
        pc_branch = '0;
        id_ex_jump = 1'b0;
        id_ex_hit = 1'b0;
    endtask

    task automatic drive_row(input row_t r);
        id_ex_branch = r.branch;
        pcsrc = r.src;
        id_ex_pc = r.ex_pc;
        pc_branch = r.target;
        id_ex_jump = r.jump;
        id_ex_hit = r.ex_hit;
    endtask

    task automatic compare_value(input int idx, input string sig,
                                 input logic [addr_w-1:0] expected,
                                 input logic [addr_w-1:0] actual);
        assert (actual === expected) else begin
            $display("FAILED test %0d: %s expected 0x%h, got 0x%h", idx, sig, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_row(input int idx, input row_t r);
        row_errors = 0;
        compare_value(idx, "pc", r.exp_pc, pc);
        compare_value(idx, "hit", addr_w'(r.exp_hit), addr_w'(hit));
        compare_value(idx, "pc_taken", addr_w'(r.exp_pc_taken), addr_w'(pc_taken));
        compare_value(idx, "miss_redirect", addr_w'(r.exp_miss), addr_w'(miss_redirect));
        compare_value(idx, "wrong", addr_w'(r.exp_wrong), addr_w'(wrong));
        if (row_errors == 0) begin
            $display("test %0d %s: ok", idx, names[idx]);
        end else begin
            $display("test %0d %s: %0d mismatch(es)", idx, names[idx], row_errors);
            failed_tests++;
            total_errors += row_errors;
        end
    endtask

    initial begin
        reset = 1'b1;
        idle_inputs();
        total_errors = 0;
        failed_tests = 0;
        prop_failures = 0;
        load_table();
        rows_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        // Drive just after one edge, check at the falling edge
        foreach (rows[i]) begin
            drive_row(rows[i]);
            @(negedge clk);
            check_row(i, rows[i]);
            @(posedge clk);
            #2;
        end
        idle_inputs();
        repeat (4) @(posedge clk);
        // Bound checker keeps its own tally
        prop_failures = global_prediction_top_i.props_i.fail_count;
        $display("tests %0d, ok %0d, failed %0d, mismatches %0d, property failures %0d",
                 rows.size(), rows.size() - failed_tests, failed_tests, total_errors,
                 prop_failures);
        if (total_errors == 0 && prop_failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        longint limit_ns;
        wait (rows_loaded);
        // Rows plus reset and drain, half again as margin
        limit_ns = (longint'(rows.size()) + 20) * period_ns * 3 / 2;
        #(limit_ns);
        $display("ERROR: run timed out after %0d ns before all tests finished", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
bp_pkg.sv
global_history_register.sv
pattern_history_table.sv
branch_target_buffer.sv
branch_correction_buffer.sv
fetch_pc_select.sv
global_prediction_top.sv
tb_clock_gen.sv
global_prediction_properties.sv
global_prediction_tb.sv
